/* hw/icache_params.svh */
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cache geometry

`define ICACHE_ADDR_BITS   32 // fetch address width
`define ICACHE_OFFSET_BITS 5  // 32 bytes per line
`define ICACHE_INDEX_BITS  4  // 16 lines
`define ICACHE_BEAT_BITS   64 // one memory beat
`define ICACHE_INSTR_BITS  32

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// derived widths

`define ICACHE_ALIGN_BITS    $clog2(`ICACHE_BEAT_BITS / 8) // byte offset within a beat
`define ICACHE_BEAT_IDX_BITS (`ICACHE_OFFSET_BITS - `ICACHE_ALIGN_BITS)
`define ICACHE_TAG_BITS      (`ICACHE_ADDR_BITS - `ICACHE_INDEX_BITS - `ICACHE_OFFSET_BITS)

`endif

/* hw/icache_pkg.sv */
`include "icache_params.svh"

package icache_pkg;

	// fetch address and line address share one type
	typedef logic [`ICACHE_ADDR_BITS-1:0] addr_t;

	typedef logic [`ICACHE_INSTR_BITS-1:0] instr_t;

	typedef logic [`ICACHE_BEAT_BITS-1:0] beat_t; // one burst beat from memory

	typedef logic [`ICACHE_INDEX_BITS-1:0] index_t;

	typedef logic [`ICACHE_TAG_BITS-1:0] tag_t; // address bits above index and offset

	typedef logic [`ICACHE_BEAT_IDX_BITS-1:0] beat_idx_t; // four beats make a line

	// refill sequencing
	typedef enum logic {
		IDLE  = 1'b0,
		FETCH = 1'b1
	} refill_state_t;

endpackage

/* hw/single_port_ram.sv */
`timescale 1ns/1ps

module single_port_ram #(
	parameter int ADDR_WIDTH = 4,
	parameter int DATA_WIDTH = 32
) (
	input  logic                  clk,
	input  logic [ADDR_WIDTH-1:0] addr,
	input  logic                  wen,
	input  logic [DATA_WIDTH-1:0] wdata,
	output logic [DATA_WIDTH-1:0] rdata
);

	logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH]; // contents undefined until written

	always_ff @(posedge clk) begin
		if (wen) begin
			mem[addr] <= wdata;
		end
	end

	assign rdata = mem[addr]; // read is combinational so a hit needs no extra cycle

endmodule

/* hw/icache_lookup.sv */
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_lookup (
	input  logic               clk,
	input  logic               reset,
	input  icache_pkg::addr_t  ireq_addr,
	input  logic               fill_done,
	output logic               hit
);

	localparam int NUM_LINES = 2 ** `ICACHE_INDEX_BITS;

	icache_pkg::index_t index;
	icache_pkg::tag_t   tag;
	icache_pkg::tag_t   stored_tag;

	logic [NUM_LINES-1:0] line_valid;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// address split

	assign index = ireq_addr[`ICACHE_OFFSET_BITS + `ICACHE_INDEX_BITS - 1 -: `ICACHE_INDEX_BITS];
	assign tag   = ireq_addr[`ICACHE_ADDR_BITS - 1 -: `ICACHE_TAG_BITS];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// line state

	always_ff @(posedge clk) begin
		if (reset) begin
			line_valid <= '0;
		end else if (fill_done) begin
			line_valid[index] <= 1'b1; // the held address still points at the filled line
		end
	end

	single_port_ram #(
		.ADDR_WIDTH(`ICACHE_INDEX_BITS),
		.DATA_WIDTH(`ICACHE_TAG_BITS)
	) i_tag_ram (
		.clk   (clk),
		.addr  (index),
		.wen   (fill_done), // tag lands together with the valid bit
		.wdata (tag),
		.rdata (stored_tag)
	);

	assign hit = line_valid[index] && (stored_tag == tag);

endmodule

/* hw/icache_refill.sv */
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_refill (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   ireq_valid,
	input  icache_pkg::addr_t      ireq_addr,
	input  logic                   hit,
	input  logic                   cresp_ready,
	input  logic                   cresp_last,
	output logic                   creq_valid,
	output icache_pkg::addr_t      creq_addr,
	output icache_pkg::beat_idx_t  beat_idx,
	output logic                   data_wen,
	output logic                   fill_done,
	output logic                   iresp_data_ok
);

	icache_pkg::refill_state_t state;
	icache_pkg::refill_state_t state_nxt;
	icache_pkg::beat_idx_t     beat_cnt;
	icache_pkg::beat_idx_t     beat_cnt_nxt;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// next state

	always_comb begin
		state_nxt    = state;
		beat_cnt_nxt = beat_cnt;
		data_wen     = 1'b0;
		fill_done    = 1'b0;
		unique case (state)
			icache_pkg::IDLE: begin
				if (ireq_valid && !hit) begin
					state_nxt    = icache_pkg::FETCH;
					beat_cnt_nxt = '0;
				end
			end
			icache_pkg::FETCH: begin
				if (cresp_ready) begin
					data_wen     = 1'b1; // every strobe carries one beat
					beat_cnt_nxt = icache_pkg::beat_idx_t'(beat_cnt + 1'b1);
					if (cresp_last) begin
						state_nxt    = icache_pkg::IDLE;
						beat_cnt_nxt = '0;
						fill_done    = 1'b1;
					end
				end
			end
			default: begin
				state_nxt = icache_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= icache_pkg::IDLE;
			beat_cnt <= '0;
		end else begin
			state    <= state_nxt;
			beat_cnt <= beat_cnt_nxt;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// outputs

	assign beat_idx   = beat_cnt;
	assign creq_valid = (state == icache_pkg::FETCH); // held high across beat gaps
	assign creq_addr  = {ireq_addr[`ICACHE_ADDR_BITS-1:`ICACHE_OFFSET_BITS],
		{`ICACHE_OFFSET_BITS{1'b0}}};

	// data array is being written during a fill so no response then
	assign iresp_data_ok = (state == icache_pkg::IDLE) && ireq_valid && hit;

endmodule

/* hw/icache_data_array.sv */
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_data_array (
	input  logic                   clk,
	input  icache_pkg::addr_t      ireq_addr,
	input  logic                   fill_active,
	input  icache_pkg::beat_idx_t  beat_idx,
	input  logic                   data_wen,
	input  icache_pkg::beat_t      cresp_data,
	output icache_pkg::instr_t     iresp_data
);

	localparam int RAM_ADDR_BITS = `ICACHE_INDEX_BITS + `ICACHE_BEAT_IDX_BITS;

	icache_pkg::index_t       index;
	logic [RAM_ADDR_BITS-1:0] ram_addr;
	icache_pkg::beat_t        beat_rdata;

	assign index = ireq_addr[`ICACHE_OFFSET_BITS + `ICACHE_INDEX_BITS - 1 -: `ICACHE_INDEX_BITS];

	// during a fill the beat counter picks the slot, otherwise the fetch address does
	always_comb begin
		if (fill_active) begin
			ram_addr = {index, beat_idx};
		end else begin
			ram_addr = ireq_addr[`ICACHE_OFFSET_BITS + `ICACHE_INDEX_BITS - 1:`ICACHE_ALIGN_BITS];
		end
	end

	single_port_ram #(
		.ADDR_WIDTH(RAM_ADDR_BITS),
		.DATA_WIDTH(`ICACHE_BEAT_BITS)
	) i_data_ram (
		.clk   (clk),
		.addr  (ram_addr),
		.wen   (data_wen),
		.wdata (cresp_data), // beats go straight in from the bus
		.rdata (beat_rdata)
	);

	// address bit 2 picks the upper word of the beat
	assign iresp_data = ireq_addr[`ICACHE_ALIGN_BITS-1] ?
		beat_rdata[`ICACHE_BEAT_BITS-1 -: `ICACHE_INSTR_BITS] :
		beat_rdata[`ICACHE_INSTR_BITS-1:0];

endmodule

/* hw/icache_top.sv */
`timescale 1ns/1ps

module icache_top (
	input  logic                clk,
	input  logic                reset,
	// fetch side
	input  logic                ireq_valid,
	input  icache_pkg::addr_t   ireq_addr,
	output logic                iresp_data_ok,
	output icache_pkg::instr_t  iresp_data,
	// memory side
	output logic                creq_valid,
	output icache_pkg::addr_t   creq_addr,
	input  logic                cresp_ready,
	input  logic                cresp_last,
	input  icache_pkg::beat_t   cresp_data
);

	logic                  hit;
	logic                  fill_done;
	logic                  data_wen;
	icache_pkg::beat_idx_t beat_idx;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// tag side

	icache_lookup i_lookup (
		.clk       (clk),
		.reset     (reset),
		.ireq_addr (ireq_addr),
		.fill_done (fill_done),
		.hit       (hit)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// miss handling

	icache_refill i_refill (
		.clk           (clk),
		.reset         (reset),
		.ireq_valid    (ireq_valid),
		.ireq_addr     (ireq_addr),
		.hit           (hit),
		.cresp_ready   (cresp_ready),
		.cresp_last    (cresp_last),
		.creq_valid    (creq_valid),
		.creq_addr     (creq_addr),
		.beat_idx      (beat_idx),
		.data_wen      (data_wen),
		.fill_done     (fill_done),
		.iresp_data_ok (iresp_data_ok)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// instruction storage

	icache_data_array i_data_array (
		.clk         (clk),
		.ireq_addr   (ireq_addr),
		.fill_active (creq_valid), // the bus request level marks a running fill
		.beat_idx    (beat_idx),
		.data_wen    (data_wen),
		.cresp_data  (cresp_data),
		.iresp_data  (iresp_data)
	);

endmodule

/* verification/cbus_memory_model.sv */
`timescale 1ns/1ps

module cbus_memory_model #(
	parameter logic [31:0] SEED = 32'hb394
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               creq_valid,
	input  icache_pkg::addr_t  creq_addr,
	output logic               cresp_ready,
	output logic               cresp_last,
	output icache_pkg::beat_t  cresp_data
);

	logic [31:0]       lfsr = SEED;
	logic              req_q;
	logic              active;
	logic [1:0]        beat;
	logic [1:0]        gap;
	logic [1:0]        next_gap;
	icache_pkg::addr_t base;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32, 22, 2, 1
	endfunction

	task automatic draw_gap(output logic [1:0] g);
		lfsr = lfsr_next(lfsr);
		g[0] = lfsr[0];
		lfsr = lfsr_next(lfsr);
		g[1] = lfsr[0];
	endtask

	// instruction at byte address a is ~a, the higher address in the upper half
	function automatic icache_pkg::beat_t beat_at(input icache_pkg::addr_t a);
		return {~(a + 32'd4), ~a};
	endfunction

	initial begin
		cresp_ready = 1'b0;
		cresp_last  = 1'b0;
		cresp_data  = '0;
	end

	always @(posedge clk) begin
		cresp_ready <= 1'b0;
		cresp_last  <= 1'b0;
		req_q       <= creq_valid;
		if (reset) begin
			active <= 1'b0;
		end else if (!active) begin
			if (creq_valid && !req_q) begin // a new line request
				draw_gap(next_gap);
				active <= 1'b1;
				base   <= creq_addr;
				beat   <= 2'd0;
				gap    <= next_gap;
			end
		end else if (gap != 2'd0) begin
			gap <= gap - 2'd1;
		end else begin
			draw_gap(next_gap);
			cresp_ready <= 1'b1;
			cresp_last  <= (beat == 2'd3);
			cresp_data  <= beat_at(base + {beat, 3'b000});
			beat        <= beat + 2'd1;
			gap         <= next_gap;
			active      <= (beat != 2'd3);
		end
	end

endmodule

/* verification/icache_tb.sv */
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_tb;

	localparam int          TIMEOUT_CYCLES = 200;
	localparam logic [31:0] SEED = 32'hb394;
	localparam int          BEATS = (2 ** `ICACHE_OFFSET_BITS) / (`ICACHE_BEAT_BITS / 8);

	logic               clk = 1'b0;
	logic               reset;
	logic               ireq_valid;
	icache_pkg::addr_t  ireq_addr;
	logic               iresp_data_ok;
	icache_pkg::instr_t iresp_data;
	logic               creq_valid;
	icache_pkg::addr_t  creq_addr;
	logic               cresp_ready;
	logic               cresp_last;
	icache_pkg::beat_t  cresp_data;

	logic [31:0]      lfsr = SEED;
	logic             exp_hit; // expected outcome of the held request
	int               beats_seen;
	int               check_errors;
	int               errors_at_start;
	int               tests_passed;
	int               tests_failed;
	string            test_name;
	logic [15:0]      ref_valid;
	icache_pkg::tag_t ref_tag [16];

	always #20 clk = ~clk;

	icache_top i_dut (
		.clk           (clk),
		.reset         (reset),
		.ireq_valid    (ireq_valid),
		.ireq_addr     (ireq_addr),
		.iresp_data_ok (iresp_data_ok),
		.iresp_data    (iresp_data),
		.creq_valid    (creq_valid),
		.creq_addr     (creq_addr),
		.cresp_ready   (cresp_ready),
		.cresp_last    (cresp_last),
		.cresp_data    (cresp_data)
	);

	cbus_memory_model #(.SEED(SEED)) i_memory (
		.clk         (clk),
		.reset       (reset),
		.creq_valid  (creq_valid),
		.creq_addr   (creq_addr),
		.cresp_ready (cresp_ready),
		.cresp_last  (cresp_last),
		.cresp_data  (cresp_data)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic icache_pkg::addr_t line_of(input icache_pkg::addr_t a);
		return a & ~icache_pkg::addr_t'((1 << `ICACHE_OFFSET_BITS) - 1);
	endfunction

	always @(posedge clk) begin
		if (reset || iresp_data_ok) begin
			beats_seen <= 0; // counts the beats of one request
		end else if (cresp_ready) begin
			beats_seen <= beats_seen + 1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checks

	data_check: assert property (@(posedge clk) disable iff (reset)
		iresp_data_ok |-> iresp_data == ~ireq_addr)
	else begin
		check_errors++;
		$display("FAIL %s: data expected %h actual %h", test_name,
			~$sampled(ireq_addr), $sampled(iresp_data));
	end

	hit_check: assert property (@(posedge clk) disable iff (reset)
		ireq_valid && exp_hit |-> iresp_data_ok && !creq_valid)
	else begin
		check_errors++;
		$display("FAIL %s: hit ok/creq expected 1/0 actual %b/%b", test_name,
			$sampled(iresp_data_ok), $sampled(creq_valid));
	end

	miss_check: assert property (@(posedge clk) disable iff (reset)
		$rose(ireq_valid) && !exp_hit |=> creq_valid)
	else begin
		check_errors++;
		$display("FAIL %s: creq_valid expected 1 actual %b", test_name, $sampled(creq_valid));
	end

	line_check: assert property (@(posedge clk) disable iff (reset)
		$rose(creq_valid) |-> creq_addr == line_of(ireq_addr))
	else begin
		check_errors++;
		$display("FAIL %s: creq_addr expected %h actual %h", test_name,
			line_of($sampled(ireq_addr)), $sampled(creq_addr));
	end

	beat_check: assert property (@(posedge clk) disable iff (reset)
		iresp_data_ok |-> beats_seen == (exp_hit ? 0 : BEATS))
	else begin
		check_errors++;
		$display("FAIL %s: beats expected %0d actual %0d", test_name,
			$sampled(exp_hit) ? 0 : BEATS, $sampled(beats_seen));
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic apply_reset();
		reset      <= 1'b1;
		ireq_valid <= 1'b0;
		repeat (5) @(posedge clk);
		reset     <= 1'b0;
		ref_valid = '0; // every line is invalid again
	endtask

	task automatic fetch(input icache_pkg::addr_t addr);
		int                 waited;
		icache_pkg::index_t idx;
		icache_pkg::tag_t   tag;
		idx = addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
		tag = addr[`ICACHE_ADDR_BITS-1 -: `ICACHE_TAG_BITS];
		@(posedge clk);
		exp_hit    <= ref_valid[idx] && (ref_tag[idx] == tag);
		ireq_valid <= 1'b1;
		ireq_addr  <= addr;
		waited = 0;
		@(negedge clk);
		while (!iresp_data_ok && waited < TIMEOUT_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		if (!iresp_data_ok) begin
			$display("%s: no response to the fetch of %h within %0d cycles", test_name, addr,
				TIMEOUT_CYCLES);
			$display("Test FAILED");
			$finish;
		end else begin
			@(posedge clk);
			ireq_valid     <= 1'b0;
			ref_valid[idx] = 1'b1;
			ref_tag[idx]   = tag;
		end
	endtask

	task automatic start_test(input string name);
		test_name       = name;
		errors_at_start = check_errors;
	endtask

	task automatic finish_test();
		if (check_errors == errors_at_start) begin
			tests_passed++;
			$display("%s: pass", test_name);
		end else begin
			tests_failed++;
			$display("%s: fail, %0d errors", test_name, check_errors - errors_at_start);
		end
	endtask

	initial begin
		logic [31:0] r;
		reset        = 1'b1;
		ireq_valid   = 1'b0;
		ireq_addr    = '0;
		exp_hit      = 1'b0;
		beats_seen   = 0;
		check_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		ref_valid    = '0;
		test_name    = "reset";
		apply_reset();

		start_test("cold_miss");
		fetch(32'h0000_2044);
		finish_test();

		start_test("line_words"); // all eight words of the filled line hit
		for (int w = 0; w < 8; w++) begin
			fetch(32'h0000_2040 + w * 4);
		end
		finish_test();

		start_test("conflict_eviction"); // same index 8, two tags
		for (int i = 0; i < 6; i++) begin
			fetch(((i % 2) ? 32'h0004_2100 : 32'h0001_3100) + i * 4);
		end
		finish_test();

		start_test("reset_clears_valid");
		apply_reset();
		fetch(32'h0000_2048);
		finish_test();

		start_test("random_beat_gaps");
		for (int i = 0; i < 40; i++) begin
			draw_bits(10, r);
			fetch({20'h0, r[9:0], 2'b00});
		end
		finish_test();

		repeat (2) @(posedge clk);
		$display("tests passed %0d, failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && check_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* src.f */
+incdir+hw
hw/icache_pkg.sv
hw/single_port_ram.sv
hw/icache_lookup.sv
hw/icache_refill.sv
hw/icache_data_array.sv
hw/icache_top.sv
verification/cbus_memory_model.sv
verification/icache_tb.sv

/* Bender.yml */
package:
  name: icache

sources:
  - include_dirs:
      - hw
    files:
      - hw/icache_pkg.sv
      - hw/single_port_ram.sv
      - hw/icache_lookup.sv
      - hw/icache_refill.sv
      - hw/icache_data_array.sv
      - hw/icache_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/cbus_memory_model.sv
      - verification/icache_tb.sv
